//--- source/exb_defs.svh
// Execute back end configuration
// Widths and sizes shared by the execute, queue and writeback stages

`ifndef EXB_DEFS_SVH
`define EXB_DEFS_SVH

// ------------------------------
// Message fields
// ------------------------------

// Bits in the in-flight sequence number
`define EXB_SEQ_NUM_BITS 5

// ------------------------------
// Storage sizes
// ------------------------------

// Default X-to-W queue depth
`define EXB_QUEUE_DEPTH 8

// Architectural registers, x0 included
`define EXB_NUM_REGS 32

`endif

//--- source/uarch_pkg.sv
// Architectural data types
// Word, sequence number and register index seen by every stage

`include "exb_defs.svh"

package uarch_pkg;

  // ------------------------------
  // Data
  // ------------------------------

  // Data word for pc, operands and write data
  typedef logic [31:0] word_t;

  // ------------------------------
  // Control fields
  // ------------------------------

  // Tag carried with each in-flight operation
  typedef logic [`EXB_SEQ_NUM_BITS-1:0] seq_num_t;

  // Register index, sized from the register count
  typedef logic [$clog2(`EXB_NUM_REGS)-1:0] reg_addr_t;

endpackage

//--- source/exec_pkg.sv
// Execute stage types
// ALU operation codes and operand views used by the execute stage

package exec_pkg;

  // ALU operation code
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    SRL = 3'd6,
    SLT = 3'd7
  } alu_op_e;

  // Shift amount from the low bits of op_b
  typedef logic [4:0] shamt_t;

  // Signed view of a data word for SLT
  typedef logic signed [$bits(uarch_pkg::word_t)-1:0] sword_t;

endpackage

//--- source/alu_unit.sv
// Execute stage
// Computes the ALU result for a decoded operation and holds one
// X-to-W message in an output register, val/rdy on both sides

`timescale 1ns/1ps

module alu_unit (
  input  logic                clk,
  input  logic                rst_n,

  // Decoded operation in
  input  logic                d_val,
  output logic                d_rdy,
  input  uarch_pkg::word_t    d_pc,
  input  uarch_pkg::seq_num_t d_seq_num,
  input  exec_pkg::alu_op_e   d_op,
  input  uarch_pkg::word_t    d_op_a,
  input  uarch_pkg::word_t    d_op_b,
  input  uarch_pkg::reg_addr_t d_waddr,
  input  logic                d_wen,

  // X-to-W message out
  output logic                x_val,
  input  logic                x_rdy,
  output uarch_pkg::word_t    x_pc,
  output uarch_pkg::seq_num_t x_seq_num,
  output uarch_pkg::reg_addr_t x_waddr,
  output uarch_pkg::word_t    x_wdata,
  output logic                x_wen
);

  // ------------------------------
  // Combinational ALU
  // ------------------------------

  uarch_pkg::word_t alu_result;
  exec_pkg::shamt_t shamt;
  exec_pkg::sword_t op_a_s;
  exec_pkg::sword_t op_b_s;

  // Shifts use only the low five bits of op_b
  assign shamt  = d_op_b[4:0];

  // Signed copies for the set-less-than compare
  assign op_a_s = d_op_a;
  assign op_b_s = d_op_b;

  always_comb begin
    case (d_op)
      exec_pkg::ADD: alu_result = d_op_a + d_op_b;
      exec_pkg::SUB: alu_result = d_op_a - d_op_b;
      exec_pkg::AND: alu_result = d_op_a & d_op_b;
      exec_pkg::OR:  alu_result = d_op_a | d_op_b;
      exec_pkg::XOR: alu_result = d_op_a ^ d_op_b;
      // Logical shifts, zero fill
      exec_pkg::SLL: alu_result = d_op_a << shamt;
      exec_pkg::SRL: alu_result = d_op_a >> shamt;
      // One when op_a is below op_b as signed values
      exec_pkg::SLT: alu_result = uarch_pkg::word_t'(op_a_s < op_b_s);
      default:       alu_result = '0;
    endcase
  end

  // ------------------------------
  // Handshake and output register
  // ------------------------------

  logic d_fire;

  // Free when empty or when the held message leaves this cycle
  assign d_rdy  = !x_val || x_rdy;
  assign d_fire = d_val && d_rdy;

  // Valid bit follows the input whenever the slot can be refilled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_val <= 1'b0;
    end else if (d_rdy) begin
      x_val <= d_val;
    end
  end

  // Payload captured only on a real transfer
  always_ff @(posedge clk) begin
    if (d_fire) begin
      x_pc      <= d_pc;
      x_seq_num <= d_seq_num;
      x_waddr   <= d_waddr;
      x_wdata   <= alu_result;
      x_wen     <= d_wen;
    end
  end

endmodule

//--- source/ex_queue.sv
// X-to-W message queue
// In-order circular buffer between execute and writeback with
// val/rdy on both sides and no bypass path

`timescale 1ns/1ps

`include "exb_defs.svh"

module ex_queue #(
  parameter int depth = `EXB_QUEUE_DEPTH
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // Enqueue side
  input  logic                 in_val,
  output logic                 in_rdy,
  input  uarch_pkg::word_t     in_pc,
  input  uarch_pkg::seq_num_t  in_seq_num,
  input  uarch_pkg::reg_addr_t in_waddr,
  input  uarch_pkg::word_t     in_wdata,
  input  logic                 in_wen,

  // Dequeue side
  output logic                 out_val,
  input  logic                 out_rdy,
  output uarch_pkg::word_t     out_pc,
  output uarch_pkg::seq_num_t  out_seq_num,
  output uarch_pkg::reg_addr_t out_waddr,
  output uarch_pkg::word_t     out_wdata,
  output logic                 out_wen
);

  // Pointer width kept at one bit or more for depth 1
  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  // Count has to reach depth itself
  localparam int cnt_bits = $clog2(depth + 1);

  // ------------------------------
  // Storage
  // ------------------------------

  uarch_pkg::word_t     pc_mem    [depth];
  uarch_pkg::seq_num_t  seq_mem   [depth];
  uarch_pkg::reg_addr_t waddr_mem [depth];
  uarch_pkg::word_t     wdata_mem [depth];
  logic                 wen_mem   [depth];

  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;

  logic enq;
  logic deq;

  // Pointer advance, wraps at depth for any size
  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    if (ptr == ptr_bits'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ------------------------------
  // Handshake
  // ------------------------------

  // Full and empty come from the count only
  assign in_rdy  = (count != cnt_bits'(depth));
  assign out_val = (count != '0);

  assign enq = in_val && in_rdy;
  assign deq = out_val && out_rdy;

  // Oldest entry presented straight from storage
  assign out_pc      = pc_mem[rd_ptr];
  assign out_seq_num = seq_mem[rd_ptr];
  assign out_waddr   = waddr_mem[rd_ptr];
  assign out_wdata   = wdata_mem[rd_ptr];
  assign out_wen     = wen_mem[rd_ptr];

  // Entry write on enqueue
  always_ff @(posedge clk) begin
    if (enq) begin
      pc_mem[wr_ptr]    <= in_pc;
      seq_mem[wr_ptr]   <= in_seq_num;
      waddr_mem[wr_ptr] <= in_waddr;
      wdata_mem[wr_ptr] <= in_wdata;
      wen_mem[wr_ptr]   <= in_wen;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (deq) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous enq and deq leave the count alone
      case ({enq, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- source/writeback_unit.sv
// Writeback stage
// Holds one message in a commit register, writes the register file
// on commit and serves a combinational read port

`timescale 1ns/1ps

`include "exb_defs.svh"

module writeback_unit (
  input  logic                 clk,
  input  logic                 rst_n,

  // Messages from the queue
  input  logic                 q_val,
  output logic                 q_rdy,
  input  uarch_pkg::word_t     q_pc,
  input  uarch_pkg::seq_num_t  q_seq_num,
  input  uarch_pkg::reg_addr_t q_waddr,
  input  uarch_pkg::word_t     q_wdata,
  input  logic                 q_wen,

  // Commit port
  output logic                 commit_val,
  input  logic                 commit_rdy,
  output uarch_pkg::word_t     commit_pc,
  output uarch_pkg::seq_num_t  commit_seq_num,
  output uarch_pkg::reg_addr_t commit_waddr,
  output uarch_pkg::word_t     commit_wdata,
  output logic                 commit_wen,

  // Register read port
  input  uarch_pkg::reg_addr_t rf_raddr,
  output uarch_pkg::word_t     rf_rdata
);

  // ------------------------------
  // Commit register
  // ------------------------------

  logic q_fire;
  logic commit_fire;

  // Accept when empty or draining this cycle
  assign q_rdy       = !commit_val || commit_rdy;
  assign q_fire      = q_val && q_rdy;
  assign commit_fire = commit_val && commit_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      commit_val <= 1'b0;
    end else if (q_rdy) begin
      commit_val <= q_val;
    end
  end

  always_ff @(posedge clk) begin
    if (q_fire) begin
      commit_pc      <= q_pc;
      commit_seq_num <= q_seq_num;
      commit_waddr   <= q_waddr;
      commit_wdata   <= q_wdata;
      commit_wen     <= q_wen;
    end
  end

  // ------------------------------
  // Register file
  // ------------------------------

  uarch_pkg::word_t rf [`EXB_NUM_REGS];
  logic             rf_we;

  // x0 never written
  assign rf_we = commit_fire && commit_wen && (commit_waddr != '0);

  // Architectural state cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `EXB_NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (rf_we) begin
      rf[commit_waddr] <= commit_wdata;
    end
  end

  // Read sees state before this cycle's commit
  assign rf_rdata = (rf_raddr == '0) ? '0 : rf[rf_raddr];

endmodule

//--- source/execute_backend.sv
// Execute back end top
// Execute stage, X-to-W queue and writeback stage in one val/rdy chain

`timescale 1ns/1ps

`include "exb_defs.svh"

module execute_backend (
  input  logic                 clk,
  input  logic                 rst_n,

  // Decoded operations in
  input  logic                 d_val,
  output logic                 d_rdy,
  input  uarch_pkg::word_t     d_pc,
  input  uarch_pkg::seq_num_t  d_seq_num,
  input  exec_pkg::alu_op_e    d_op,
  input  uarch_pkg::word_t     d_op_a,
  input  uarch_pkg::word_t     d_op_b,
  input  uarch_pkg::reg_addr_t d_waddr,
  input  logic                 d_wen,

  // Commits out
  output logic                 commit_val,
  input  logic                 commit_rdy,
  output uarch_pkg::word_t     commit_pc,
  output uarch_pkg::seq_num_t  commit_seq_num,
  output uarch_pkg::reg_addr_t commit_waddr,
  output uarch_pkg::word_t     commit_wdata,
  output logic                 commit_wen,

  // Register read port
  input  uarch_pkg::reg_addr_t rf_raddr,
  output uarch_pkg::word_t     rf_rdata
);

  // ------------------------------
  // Execute to queue
  // ------------------------------

  logic                 x_val;
  logic                 x_rdy;
  uarch_pkg::word_t     x_pc;
  uarch_pkg::seq_num_t  x_seq_num;
  uarch_pkg::reg_addr_t x_waddr;
  uarch_pkg::word_t     x_wdata;
  logic                 x_wen;

  // ------------------------------
  // Queue to writeback
  // ------------------------------

  logic                 q_val;
  logic                 q_rdy;
  uarch_pkg::word_t     q_pc;
  uarch_pkg::seq_num_t  q_seq_num;
  uarch_pkg::reg_addr_t q_waddr;
  uarch_pkg::word_t     q_wdata;
  logic                 q_wen;

  alu_unit u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_pc      (d_pc),
    .d_seq_num (d_seq_num),
    .d_op      (d_op),
    .d_op_a    (d_op_a),
    .d_op_b    (d_op_b),
    .d_waddr   (d_waddr),
    .d_wen     (d_wen),
    .x_val     (x_val),
    .x_rdy     (x_rdy),
    .x_pc      (x_pc),
    .x_seq_num (x_seq_num),
    .x_waddr   (x_waddr),
    .x_wdata   (x_wdata),
    .x_wen     (x_wen)
  );

  ex_queue #(
    .depth (`EXB_QUEUE_DEPTH)
  ) u_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_val      (x_val),
    .in_rdy      (x_rdy),
    .in_pc       (x_pc),
    .in_seq_num  (x_seq_num),
    .in_waddr    (x_waddr),
    .in_wdata    (x_wdata),
    .in_wen      (x_wen),
    .out_val     (q_val),
    .out_rdy     (q_rdy),
    .out_pc      (q_pc),
    .out_seq_num (q_seq_num),
    .out_waddr   (q_waddr),
    .out_wdata   (q_wdata),
    .out_wen     (q_wen)
  );

  writeback_unit u_wb (
    .clk            (clk),
    .rst_n          (rst_n),
    .q_val          (q_val),
    .q_rdy          (q_rdy),
    .q_pc           (q_pc),
    .q_seq_num      (q_seq_num),
    .q_waddr        (q_waddr),
    .q_wdata        (q_wdata),
    .q_wen          (q_wen),
    .commit_val     (commit_val),
    .commit_rdy     (commit_rdy),
    .commit_pc      (commit_pc),
    .commit_seq_num (commit_seq_num),
    .commit_waddr   (commit_waddr),
    .commit_wdata   (commit_wdata),
    .commit_wen     (commit_wen),
    .rf_raddr       (rf_raddr),
    .rf_rdata       (rf_rdata)
  );

endmodule

//--- verification/execute_backend_tb.sv
// Execute back end testbench
// Random operations from an LFSR through the full val/rdy chain,
// commits checked in order against a model and a shadow register file

`timescale 1ns/1ps

`include "exb_defs.svh"

module execute_backend_tb;

  // Messages the chain can hold between input and commit
  localparam int max_in_flight = `EXB_QUEUE_DEPTH + 2;
  localparam int wait_limit    = 200;

  logic                 clk;
  logic                 rst_n;
  logic                 d_val;
  logic                 d_rdy;
  uarch_pkg::word_t     d_pc;
  uarch_pkg::seq_num_t  d_seq_num;
  exec_pkg::alu_op_e    d_op;
  uarch_pkg::word_t     d_op_a;
  uarch_pkg::word_t     d_op_b;
  uarch_pkg::reg_addr_t d_waddr;
  logic                 d_wen;
  logic                 commit_val;
  logic                 commit_rdy;
  uarch_pkg::word_t     commit_pc;
  uarch_pkg::seq_num_t  commit_seq_num;
  uarch_pkg::reg_addr_t commit_waddr;
  uarch_pkg::word_t     commit_wdata;
  logic                 commit_wen;
  uarch_pkg::reg_addr_t rf_raddr;
  uarch_pkg::word_t     rf_rdata;

  execute_backend dut (.*);

  // ------------------------------
  // Model state
  // ------------------------------

  logic [15:0]          lfsr_state;
  // 0 ready, 1 stalled, 2 random
  int                   sink_mode;
  logic                 in_fire;
  uarch_pkg::word_t     rd_sample;
  uarch_pkg::word_t     exp_pc    [$];
  uarch_pkg::seq_num_t  exp_seq   [$];
  uarch_pkg::reg_addr_t exp_waddr [$];
  uarch_pkg::word_t     exp_wdata [$];
  logic                 exp_wen   [$];
  uarch_pkg::word_t     shadow_rf [`EXB_NUM_REGS];
  uarch_pkg::word_t     next_pc;
  uarch_pkg::seq_num_t  next_seq;
  int                   x0_writes;

  always #50 clk = ~clk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Reference ALU rules
  function automatic uarch_pkg::word_t model_alu(input exec_pkg::alu_op_e op,
                                                 input uarch_pkg::word_t a,
                                                 input uarch_pkg::word_t b);
    exec_pkg::shamt_t sh;
    sh = b[4:0];
    case (op)
      exec_pkg::ADD: return a + b;
      exec_pkg::SUB: return a - b;
      exec_pkg::AND: return a & b;
      exec_pkg::OR:  return a | b;
      exec_pkg::XOR: return a ^ b;
      exec_pkg::SLL: return a << sh;
      exec_pkg::SRL: return a >> sh;
      // Signed compare giving 0 or 1
      exec_pkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:       return '0;
    endcase
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_word(input uarch_pkg::word_t got, input uarch_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("[ERROR] t=%0d ns: %s is %h, expected %h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_seq(input uarch_pkg::seq_num_t got, input uarch_pkg::seq_num_t exp,
                           input string what);
    if (got !== exp) begin
      $display("[ERROR] t=%0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_addr(input uarch_pkg::reg_addr_t got,
                            input uarch_pkg::reg_addr_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] t=%0d ns: %s is x%0d, expected x%0d", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] t=%0d ns: %s is %b, expected %b", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  // ------------------------------
  // Cycle stepping
  // ------------------------------

  // Outputs settle by the falling edge and transfer at the next rise
  task automatic sample_ports();
    rd_sample = rf_rdata;
    if (commit_val && commit_rdy) begin
      if (exp_pc.size() == 0) begin
        $display("A commit appeared with no operation outstanding at %0d ns", $time);
        stop_on_failure();
      end
      check_word(commit_pc, exp_pc[0], "commit_pc");
      check_seq(commit_seq_num, exp_seq[0], "commit_seq_num");
      check_addr(commit_waddr, exp_waddr[0], "commit_waddr");
      check_bit(commit_wen, exp_wen[0], "commit_wen");
      check_word(commit_wdata, exp_wdata[0], "commit_wdata");
      if (exp_wen[0] && exp_waddr[0] != '0) begin
        shadow_rf[exp_waddr[0]] = exp_wdata[0];
      end
      void'(exp_pc.pop_front());
      void'(exp_seq.pop_front());
      void'(exp_waddr.pop_front());
      void'(exp_wdata.pop_front());
      void'(exp_wen.pop_front());
    end
    in_fire = d_val && d_rdy;
    if (in_fire) begin
      exp_pc.push_back(d_pc);
      exp_seq.push_back(d_seq_num);
      exp_waddr.push_back(d_waddr);
      exp_wdata.push_back(model_alu(d_op, d_op_a, d_op_b));
      exp_wen.push_back(d_wen);
      if (d_wen && d_waddr == '0) begin
        x0_writes++;
      end
    end
  endtask

  // One cycle that ends just after the rising edge
  task automatic tick();
    @(negedge clk);
    sample_ports();
    @(posedge clk);
    case (sink_mode)
      0:       commit_rdy <= 1'b1;
      1:       commit_rdy <= 1'b0;
      default: commit_rdy <= 1'(rand_bits(1));
    endcase
  endtask

  // ------------------------------
  // Source side
  // ------------------------------

  // New payload with x0 picked now and then
  task automatic load_op(input int kind);
    d_val     <= 1'b1;
    d_pc      <= next_pc;
    d_seq_num <= next_seq;
    if (kind < 0) begin
      d_op <= exec_pkg::alu_op_e'(rand_bits(3));
    end else begin
      d_op <= exec_pkg::alu_op_e'(kind);
    end
    d_op_a    <= rand_bits(32);
    d_op_b    <= rand_bits(32);
    d_waddr   <= (rand_bits(3) == 0) ? '0 : uarch_pkg::reg_addr_t'(rand_bits(5));
    d_wen     <= (rand_bits(2) != 0);
    next_pc   = next_pc + 32'd4;
    next_seq  = next_seq + 1'b1;
  endtask

  task automatic wait_accept();
    int waited;
    waited = 0;
    tick();
    while (!in_fire) begin
      waited++;
      if (waited > wait_limit) begin
        $display("Timeout: the DUT did not accept an operation within %0d cycles", wait_limit);
        stop_on_failure();
      end
      tick();
    end
  endtask

  task automatic send_ops(input int count, input bit cycle_ops, input bit gaps);
    for (int i = 0; i < count; i++) begin
      d_val <= 1'b0;
      if (gaps) begin
        repeat (int'(rand_bits(2))) begin
          tick();
        end
      end
      load_op(cycle_ops ? (i % 8) : -1);
      wait_accept();
    end
    d_val <= 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_pc.size() != 0) begin
      waited++;
      if (waited > wait_limit) begin
        $display("Timeout: %0d operations never committed", exp_pc.size());
        stop_on_failure();
      end
      tick();
    end
  endtask

  // Back-pressure from the commit port all the way to d_rdy
  task automatic fill_until_stall();
    int accepted;
    accepted = 0;
    sink_mode = 1;
    tick();
    load_op(-1);
    tick();
    while (in_fire) begin
      accepted++;
      if (accepted > max_in_flight) begin
        $display("d_rdy stayed high after %0d messages with commit_rdy low", accepted);
        stop_on_failure();
      end
      load_op(-1);
      tick();
    end
    // Held operation goes in once commits resume
    sink_mode = 0;
    wait_accept();
    d_val <= 1'b0;
    wait_drained();
  endtask

  task automatic check_regs();
    for (int i = 0; i < `EXB_NUM_REGS; i++) begin
      rf_raddr <= uarch_pkg::reg_addr_t'(i);
      tick();
      check_word(rd_sample, shadow_rf[i], $sformatf("register x%0d", i));
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    d_val      = 1'b0;
    d_pc       = '0;
    d_seq_num  = '0;
    d_op       = exec_pkg::ADD;
    d_op_a     = '0;
    d_op_b     = '0;
    d_waddr    = '0;
    d_wen      = 1'b0;
    commit_rdy = 1'b1;
    rf_raddr   = '0;
    lfsr_state = 16'd24184;
    sink_mode  = 0;
    next_pc    = 32'h0000_1000;
    next_seq   = '0;
    x0_writes  = 0;
    for (int i = 0; i < `EXB_NUM_REGS; i++) begin
      shadow_rf[i] = '0;
    end

    repeat (5) begin
      tick();
    end
    rst_n <= 1'b1;
    tick();

    // Idle state after reset
    @(negedge clk);
    check_bit(commit_val, 1'b0, "commit_val after reset");
    check_bit(d_rdy, 1'b1, "d_rdy after reset");
    @(posedge clk);
    check_regs();

    // Full-rate stream over every op kind
    send_ops(40, 1'b1, 1'b0);
    wait_drained();

    fill_until_stall();

    // Random traffic at both ends
    sink_mode = 2;
    send_ops(200, 1'b0, 1'b1);
    sink_mode = 0;
    wait_drained();

    check_regs();

    if (x0_writes > 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("No operation with wen high targeted x0, so x0 was never tested");
      stop_on_failure();
    end
  end

endmodule

//--- execute_backend.f
+incdir+source
source/uarch_pkg.sv
source/exec_pkg.sv
source/alu_unit.sv
source/ex_queue.sv
source/writeback_unit.sv
source/execute_backend.sv
verification/execute_backend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execute back end testbench with Verilator and runs it
# Pass or fail is taken from the simulation log

verilator --binary --timing -Wno-fatal --top-module execute_backend_tb \
  -f execute_backend.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vexecute_backend_tb > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
